//--- core_pkg.sv
`default_nettype none

package core_pkg;

    // Datapath and register index widths
    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // BR_JUMP covers both JAL and JALR
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JUMP
    } br_op_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

endpackage

`default_nettype wire

//--- core_regfile.sv
`default_nettype none

module core_regfile import core_pkg::*; (
    input  logic                  clk_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // x0 is hardwired, so its entry is never written
    always_ff @(posedge clk_i) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- core_ifu.sv
`default_nettype none

module core_ifu import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            pc_wen_i,
    input  logic [XLEN-1:0] next_pc_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [31:0]     imem_rdata_i,
    output logic [31:0]     inst_o,
    output logic [XLEN-1:0] pc_o,
    output logic            fetch_valid_o
);

    logic [XLEN-1:0] pc_q;
    logic            fetch_pending_q;

    // Pending is set out of reset so the first fetch happens right away
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q            <= RESET_PC;
            fetch_pending_q <= 1'b1;
            fetch_valid_o   <= 1'b0;
        end else begin
            fetch_pending_q <= pc_wen_i;
            fetch_valid_o   <= fetch_pending_q;
            if (pc_wen_i) begin
                pc_q <= next_pc_i;
            end
        end
    end

    // Instruction memory answers in the same cycle
    always_ff @(posedge clk_i) begin
        if (fetch_pending_q) begin
            inst_o <= imem_rdata_i;
        end
    end

    assign imem_addr_o = pc_q;
    // PC only moves on pc_wen, long after decode has taken it
    assign pc_o        = pc_q;

endmodule

`default_nettype wire

//--- core_idu.sv
`default_nettype none

module core_idu import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  fetch_valid_i,
    input  logic [31:0]           inst_i,
    input  logic [XLEN-1:0]       pc_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic [XLEN-1:0]       op_a_o,
    output logic [XLEN-1:0]       op_b_o,
    output logic [XLEN-1:0]       rs1_val_o,
    output logic [XLEN-1:0]       rs2_val_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output alu_op_e               alu_op_o,
    output br_op_e                br_op_o,
    output wb_sel_e               wb_sel_o,
    output logic                  mem_we_o,
    output logic                  dec_valid_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] op_a_d;
    logic [XLEN-1:0] op_b_d;
    logic [XLEN-1:0] rs1_val_d;
    logic [XLEN-1:0] imm_d;
    alu_op_e         alu_op_d;
    br_op_e          br_op_d;
    wb_sel_e         wb_sel_d;
    logic            mem_we_d;

    // funct7 bit 5 selects SUB and SRA
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic br_op_e br_from_funct(input logic [2:0] f3);
        case (f3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;
        endcase
    endfunction

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7_b5  = inst_i[30];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        op_a_d    = rs1_data_i;
        op_b_d    = imm_i;
        rs1_val_d = rs1_data_i;
        imm_d     = imm_i;
        alu_op_d  = ALU_ADD;
        br_op_d   = BR_NONE;
        wb_sel_d  = WB_NONE;
        mem_we_d  = 1'b0;
        case (opcode)
            OPC_LUI: begin
                op_a_d   = '0;
                op_b_d   = imm_u;
                imm_d    = imm_u;
                alu_op_d = ALU_PASS_B;
                wb_sel_d = WB_ALU;
            end
            OPC_AUIPC: begin
                op_a_d   = pc_i;
                op_b_d   = imm_u;
                imm_d    = imm_u;
                wb_sel_d = WB_ALU;
            end
            OPC_JAL: begin
                // Branch unit adds the immediate to this base, here the PC itself
                rs1_val_d = pc_i;
                imm_d     = imm_j;
                br_op_d   = BR_JUMP;
                wb_sel_d  = WB_PC4;
            end
            OPC_JALR: begin
                br_op_d  = BR_JUMP;
                wb_sel_d = WB_PC4;
            end
            OPC_BRANCH: begin
                imm_d   = imm_b;
                br_op_d = br_from_funct(funct3);
            end
            OPC_LOAD: begin
                wb_sel_d = WB_MEM;
            end
            OPC_STORE: begin
                op_b_d   = imm_s;
                imm_d    = imm_s;
                mem_we_d = 1'b1;
            end
            OPC_OPIMM: begin
                alu_op_d = alu_from_funct(funct3, (funct3 == 3'b101) && funct7_b5);
                wb_sel_d = WB_ALU;
            end
            OPC_OP: begin
                op_b_d   = rs2_data_i;
                alu_op_d = alu_from_funct(funct3, funct7_b5);
                wb_sel_d = WB_ALU;
            end
            default: begin
                // Unknown opcodes fall through as a no-op
                wb_sel_d = WB_NONE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_op_o    <= ALU_ADD;
            br_op_o     <= BR_NONE;
            wb_sel_o    <= WB_NONE;
            mem_we_o    <= 1'b0;
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= fetch_valid_i;
            if (fetch_valid_i) begin
                alu_op_o <= alu_op_d;
                br_op_o  <= br_op_d;
                wb_sel_o <= wb_sel_d;
                mem_we_o <= mem_we_d;
            end
        end
    end

    // Operands stay put until the next decode
    always_ff @(posedge clk_i) begin
        if (fetch_valid_i) begin
            op_a_o    <= op_a_d;
            op_b_o    <= op_b_d;
            rs1_val_o <= rs1_val_d;
            rs2_val_o <= rs2_data_i;
            imm_o     <= imm_d;
            pc_o      <= pc_i;
            rd_addr_o <= inst_i[11:7];
        end
    end

endmodule

`default_nettype wire

//--- core_alu.sv
`default_nettype none

module core_alu import core_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            dec_valid_i,
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  alu_op_e         alu_op_i,
    output logic [XLEN-1:0] result_o,
    output logic            alu_valid_o
);

    logic [4:0]      shamt;
    logic [XLEN-1:0] result_d;

    assign shamt = op_b_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_d = op_a_i + op_b_i;
            ALU_SUB:    result_d = op_a_i - op_b_i;
            ALU_SLL:    result_d = op_a_i << shamt;
            ALU_SLT:    result_d = XLEN'($signed(op_a_i) < $signed(op_b_i));
            ALU_SLTU:   result_d = XLEN'(op_a_i < op_b_i);
            ALU_XOR:    result_d = op_a_i ^ op_b_i;
            ALU_SRL:    result_d = op_a_i >> shamt;
            ALU_SRA:    result_d = $unsigned($signed(op_a_i) >>> shamt);
            ALU_OR:     result_d = op_a_i | op_b_i;
            ALU_AND:    result_d = op_a_i & op_b_i;
            ALU_PASS_B: result_d = op_b_i;
            default:    result_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_valid_o <= 1'b0;
        end else begin
            alu_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i) begin
            result_o <= result_d;
        end
    end

endmodule

`default_nettype wire

//--- core_bru.sv
`default_nettype none

module core_bru import core_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            dec_valid_i,
    input  br_op_e          br_op_i,
    input  logic [XLEN-1:0] rs1_val_i,
    input  logic [XLEN-1:0] rs2_val_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] imm_i,
    output logic            taken_o,
    output logic [XLEN-1:0] target_o,
    output logic [XLEN-1:0] pc4_o,
    output logic            bru_valid_o
);

    logic            eq;
    logic            lt;
    logic            ltu;
    logic            taken_d;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;

    assign eq  = (rs1_val_i == rs2_val_i);
    assign lt  = ($signed(rs1_val_i) < $signed(rs2_val_i));
    assign ltu = (rs1_val_i < rs2_val_i);

    always_comb begin
        case (br_op_i)
            BR_EQ:   taken_d = eq;
            BR_NE:   taken_d = !eq;
            BR_LT:   taken_d = lt;
            BR_GE:   taken_d = !lt;
            BR_LTU:  taken_d = ltu;
            BR_GEU:  taken_d = !ltu;
            BR_JUMP: taken_d = 1'b1;
            default: taken_d = 1'b0;
        endcase
    end

    // Jumps use the rs1 operand as base, which decode sets to the PC for JAL
    assign base = (br_op_i == BR_JUMP) ? rs1_val_i : pc_i;
    assign sum  = base + imm_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            taken_o     <= 1'b0;
            bru_valid_o <= 1'b0;
        end else begin
            bru_valid_o <= dec_valid_i;
            if (dec_valid_i) begin
                taken_o <= taken_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i) begin
            // Bit zero cleared for JALR; already zero for branches and JAL
            target_o <= {sum[XLEN-1:1], 1'b0};
            pc4_o    <= pc_i + XLEN'(4);
        end
    end

endmodule

`default_nettype wire

//--- core_lsu.sv
`default_nettype none

module core_lsu import core_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            alu_valid_i,
    input  logic [XLEN-1:0] alu_result_i,
    input  logic [XLEN-1:0] store_data_i,
    input  logic            mem_we_i,
    input  wb_sel_e         wb_sel_i,
    output logic [XLEN-1:0] dmem_addr_o,
    output logic [XLEN-1:0] dmem_wdata_o,
    output logic            dmem_we_o,
    input  logic [XLEN-1:0] dmem_rdata_i,
    output logic [XLEN-1:0] load_data_o,
    output logic            mem_done_o
);

    // Memory port is live in the cycle the ALU result appears
    assign dmem_addr_o  = alu_result_i;
    assign dmem_wdata_o = store_data_i;
    assign dmem_we_o    = alu_valid_i && mem_we_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_done_o <= 1'b0;
        end else begin
            mem_done_o <= alu_valid_i;
        end
    end

    // Read data is combinational, so capture it at the end of the access cycle
    always_ff @(posedge clk_i) begin
        if (alu_valid_i && (wb_sel_i == WB_MEM)) begin
            load_data_o <= dmem_rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- core_wbu.sv
`default_nettype none

module core_wbu import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  mem_done_i,
    input  wb_sel_e               wb_sel_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic [XLEN-1:0]       alu_result_i,
    input  logic [XLEN-1:0]       load_data_i,
    input  logic [XLEN-1:0]       pc4_i,
    input  logic                  taken_i,
    input  logic [XLEN-1:0]       target_i,
    input  logic [XLEN-1:0]       pc_i,
    output logic                  rf_we_o,
    output logic [REG_ADDR_W-1:0] rf_waddr_o,
    output logic [XLEN-1:0]       rf_wdata_o,
    output logic                  pc_wen_o,
    output logic [XLEN-1:0]       next_pc_o,
    output logic                  retire_valid_o,
    output logic [XLEN-1:0]       retire_pc_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_wdata_o
);

    logic                  writes_rd;
    logic [REG_ADDR_W-1:0] rd_eff;
    logic [XLEN-1:0]       wdata;

    always_comb begin
        case (wb_sel_i)
            WB_ALU:  wdata = alu_result_i;
            WB_MEM:  wdata = load_data_i;
            WB_PC4:  wdata = pc4_i;
            default: wdata = '0;
        endcase
    end

    assign writes_rd = (wb_sel_i != WB_NONE);
    // Nothing written shows as rd zero in the retire record
    assign rd_eff    = writes_rd ? rd_addr_i : '0;

    assign rf_we_o    = mem_done_i && writes_rd;
    assign rf_waddr_o = rd_addr_i;
    assign rf_wdata_o = wdata;
    assign pc_wen_o   = mem_done_i;
    assign next_pc_o  = taken_i ? target_i : pc4_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= mem_done_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_done_i) begin
            retire_pc_o    <= pc_i;
            retire_rd_o    <= rd_eff;
            retire_wdata_o <= (rd_eff == '0) ? '0 : wdata;
        end
    end

endmodule

`default_nettype wire

//--- core_top.sv
`default_nettype none

module core_top import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    output logic [XLEN-1:0]       imem_addr_o,
    input  logic [31:0]           imem_rdata_i,
    output logic [XLEN-1:0]       dmem_addr_o,
    output logic [XLEN-1:0]       dmem_wdata_o,
    output logic                  dmem_we_o,
    input  logic [XLEN-1:0]       dmem_rdata_i,
    output logic                  retire_valid_o,
    output logic [XLEN-1:0]       retire_pc_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_wdata_o
);

    // Register file
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    // Fetch to decode
    logic [31:0]           inst;
    logic [XLEN-1:0]       fetch_pc;
    logic                  fetch_valid;

    // Decode to execute and later stages
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       dec_pc;
    logic [REG_ADDR_W-1:0] rd_addr;
    alu_op_e               alu_op;
    br_op_e                br_op;
    wb_sel_e               wb_sel;
    logic                  mem_we;
    logic                  dec_valid;

    // Execute, memory and write-back
    logic [XLEN-1:0]       alu_result;
    logic                  alu_valid;
    logic                  taken;
    logic [XLEN-1:0]       target;
    logic [XLEN-1:0]       pc4;
    logic [XLEN-1:0]       load_data;
    logic                  mem_done;
    logic                  pc_wen;
    logic [XLEN-1:0]       next_pc;

    core_regfile i_core_regfile (
        .clk_i    (clk_i),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .we_i     (rf_we),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    core_ifu #(
        .RESET_PC (RESET_PC)
    ) i_core_ifu (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .pc_wen_i      (pc_wen),
        .next_pc_i     (next_pc),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .inst_o        (inst),
        .pc_o          (fetch_pc),
        .fetch_valid_o (fetch_valid)
    );

    core_idu i_core_idu (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .fetch_valid_i (fetch_valid),
        .inst_i        (inst),
        .pc_i          (fetch_pc),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .rs1_val_o     (rs1_val),
        .rs2_val_o     (rs2_val),
        .imm_o         (imm),
        .pc_o          (dec_pc),
        .rd_addr_o     (rd_addr),
        .alu_op_o      (alu_op),
        .br_op_o       (br_op),
        .wb_sel_o      (wb_sel),
        .mem_we_o      (mem_we),
        .dec_valid_o   (dec_valid)
    );

    core_alu i_core_alu (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dec_valid_i (dec_valid),
        .op_a_i      (op_a),
        .op_b_i      (op_b),
        .alu_op_i    (alu_op),
        .result_o    (alu_result),
        .alu_valid_o (alu_valid)
    );

    // Branch unit runs in lockstep with the ALU, so its valid goes unused
    core_bru i_core_bru (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dec_valid_i (dec_valid),
        .br_op_i     (br_op),
        .rs1_val_i   (rs1_val),
        .rs2_val_i   (rs2_val),
        .pc_i        (dec_pc),
        .imm_i       (imm),
        .taken_o     (taken),
        .target_o    (target),
        .pc4_o       (pc4),
        .bru_valid_o ()
    );

    core_lsu i_core_lsu (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .alu_valid_i  (alu_valid),
        .alu_result_i (alu_result),
        .store_data_i (rs2_val),
        .mem_we_i     (mem_we),
        .wb_sel_i     (wb_sel),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i),
        .load_data_o  (load_data),
        .mem_done_o   (mem_done)
    );

    core_wbu i_core_wbu (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .mem_done_i     (mem_done),
        .wb_sel_i       (wb_sel),
        .rd_addr_i      (rd_addr),
        .alu_result_i   (alu_result),
        .load_data_i    (load_data),
        .pc4_i          (pc4),
        .taken_i        (taken),
        .target_i       (target),
        .pc_i           (dec_pc),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .pc_wen_o       (pc_wen),
        .next_pc_o      (next_pc),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wdata_o (retire_wdata_o)
    );

endmodule

`default_nettype wire

//--- core_tb.sv
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int CLK_HALF     = 20;
    localparam int MEM_WORDS    = 256;
    localparam int CASE_WORDS   = 512;
    localparam int HDR_WORDS    = 3;
    localparam int RETIRE_GAP   = 5;

    logic                  clk = 1'b0;
    logic                  arst_n = 1'b0;
    logic [XLEN-1:0]       imem_addr;
    logic [31:0]           imem_rdata;
    logic [XLEN-1:0]       dmem_addr;
    logic [XLEN-1:0]       dmem_wdata;
    logic                  dmem_we;
    logic [XLEN-1:0]       dmem_rdata;
    logic                  retire_valid;
    logic [XLEN-1:0]       retire_pc;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_wdata;

    logic [31:0]     cases [CASE_WORDS];
    logic [31:0]     imem [MEM_WORDS];
    logic [XLEN-1:0] dmem [MEM_WORDS];

    int prog_len = 0;
    int retire_total = 0;
    int data_total = 0;
    bit cases_loaded = 1'b0;
    int retire_idx = 0;
    int cycle_cnt = 0;
    int last_retire_cycle = 0;
    int retire_errs = 0;
    int timing_errs = 0;
    int data_errs = 0;
    int case_errs = 0;

    core_top #(
        .RESET_PC (32'h0000_0000)
    ) i_core_top (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .imem_addr_o    (imem_addr),
        .imem_rdata_i   (imem_rdata),
        .dmem_addr_o    (dmem_addr),
        .dmem_wdata_o   (dmem_wdata),
        .dmem_we_o      (dmem_we),
        .dmem_rdata_i   (dmem_rdata),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_wdata_o (retire_wdata)
    );

    initial begin
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // Both memories answer combinationally, word addressed
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    // Data memory is cleared while reset is held
    always @(posedge clk) begin
        int w;
        if (!arst_n) begin
            for (w = 0; w < MEM_WORDS; w++) begin
                dmem[w] <= '0;
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // Clock cycles since reset release
    always @(posedge clk) begin
        if (arst_n) begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic load_cases();
        int i;
        $readmemh("core_cases.hex", cases);
        prog_len     = int'(cases[0]);
        retire_total = int'(cases[1]);
        data_total   = int'(cases[2]);
        assert ((prog_len > 0) && (prog_len <= MEM_WORDS) && (retire_total > 0)) else begin
            $display("Error: core_cases.hex holds no usable program or no retire records");
            case_errs++;
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog_len) ? cases[HDR_WORDS + i] : 32'h0;
        end
        cases_loaded = 1'b1;
    endtask

    task automatic check_retire();
        int                    base;
        logic [XLEN-1:0]       exp_pc;
        logic [REG_ADDR_W-1:0] exp_rd;
        logic [XLEN-1:0]       exp_wdata;
        base      = HDR_WORDS + prog_len + 3 * retire_idx;
        exp_pc    = cases[base];
        exp_rd    = cases[base + 1][REG_ADDR_W-1:0];
        exp_wdata = cases[base + 2];
        // First retire is also five cycles after reset release
        assert (cycle_cnt - last_retire_cycle == RETIRE_GAP) else begin
            $display("Error: retire %0d came %0d cycles after the previous one instead of %0d",
                     retire_idx, cycle_cnt - last_retire_cycle, RETIRE_GAP);
            timing_errs++;
        end
        assert (retire_pc == exp_pc) else begin
            $display("Error: retire_pc_o at retire %0d expected %08h actual %08h",
                     retire_idx, exp_pc, retire_pc);
            retire_errs++;
        end
        assert (retire_rd == exp_rd) else begin
            $display("Error: retire_rd_o at retire %0d expected %02h actual %02h",
                     retire_idx, exp_rd, retire_rd);
            retire_errs++;
        end
        assert (retire_wdata == exp_wdata) else begin
            $display("Error: retire_wdata_o at retire %0d expected %08h actual %08h",
                     retire_idx, exp_wdata, retire_wdata);
            retire_errs++;
        end
        last_retire_cycle = cycle_cnt;
        retire_idx++;
    endtask

    task automatic check_data_words();
        int              base;
        int              k;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] exp_val;
        logic [XLEN-1:0] act_val;
        base = HDR_WORDS + prog_len + 3 * retire_total;
        for (k = 0; k < data_total; k++) begin
            addr    = cases[base + 2 * k];
            exp_val = cases[base + 2 * k + 1];
            act_val = dmem[addr[9:2]];
            assert (act_val == exp_val) else begin
                $display("Error: dmem[%08h] expected %08h actual %08h", addr, exp_val, act_val);
                data_errs++;
            end
        end
    endtask

    function automatic int error_sum();
        return retire_errs + timing_errs + data_errs + case_errs;
    endfunction

    task automatic report_counts();
        $display("Errors: retire %0d, timing %0d, data memory %0d, case file %0d",
                 retire_errs, timing_errs, data_errs, case_errs);
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (!arst_n) begin
            assert (retire_valid === 1'b0) else begin
                $display("Error: retire_valid_o during reset expected 0 actual %h",
                         retire_valid);
                timing_errs++;
            end
            assert (dmem_we === 1'b0) else begin
                $display("Error: dmem_we_o during reset expected 0 actual %h", dmem_we);
                timing_errs++;
            end
        end else if (retire_valid && (retire_idx < retire_total)) begin
            check_retire();
        end
    end

    initial begin
        load_cases();
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        wait (retire_idx >= retire_total);
        @(negedge clk);
        check_data_words();
        report_counts();
        if (error_sum() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Margin of 20 cycles beyond reset and the expected retires
    initial begin
        wait (cases_loaded);
        repeat (RESET_CYCLES + retire_total * RETIRE_GAP + 20) @(posedge clk);
        $display("Timeout: only %0d of %0d instructions retired in time",
                 retire_idx, retire_total);
        report_counts();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- core_cases.hex
// Header: program word count, retire record count, checked data word count
// Then program words, retire records (pc rd wdata), data checks (address value)
0000003A 00000030 00000004
// Program from pc 0x00, four words per line
800000B7 FFD00113 00500193 00001217
00112293 00113313 00F1C393 0301E413
07F17493 00419513 0040D593 4040D613
003106B3 40218733 003197B3 00312833
003138B3 00314933 0030D9B3 4030DA33
00316AB3 00317B33 00718013 00300BB3
// Six branch kinds, taken then not taken, skipped slots hold addi x24
00318463 00100C13 00218463 00219463
00100C13 00319463 00314463 00100C13
0021C463 0021D463 00100C13 00315463
0021E463 00100C13 00316463 00317463
00100C13 0021F463 00C00CEF 00100C13
// JALR to an odd address, then stores, loads and a jump to itself
00100C13 0C900D13 000D0DE7 00100C13
00100C13 00100C13 10000E13 002E2023
014E2423 000E2E83 008E2F03 FE4E2E23
FFCE2F83 0000006F
// Retire records, three per line
00000000 01 80000000  00000004 02 FFFFFFFD  00000008 03 00000005
0000000C 04 0000100C  00000010 05 00000001  00000014 06 00000000
00000018 07 0000000A  0000001C 08 00000035  00000020 09 0000007D
00000024 0A 00000050  00000028 0B 08000000  0000002C 0C F8000000
00000030 0D 00000002  00000034 0E 00000008  00000038 0F 000000A0
0000003C 10 00000001  00000040 11 00000000  00000044 12 FFFFFFF8
00000048 13 04000000  0000004C 14 FC000000  00000050 15 FFFFFFFD
00000054 16 00000005  00000058 00 00000000  0000005C 17 00000005
00000060 00 00000000  00000068 00 00000000  0000006C 00 00000000
00000074 00 00000000  00000078 00 00000000  00000080 00 00000000
00000084 00 00000000  0000008C 00 00000000  00000090 00 00000000
00000098 00 00000000  0000009C 00 00000000  000000A4 00 00000000
000000A8 19 000000AC  000000B4 1A 000000C9  000000B8 1B 000000BC
000000C8 1C 00000100  000000CC 00 00000000  000000D0 00 00000000
000000D4 1D FFFFFFFD  000000D8 1E FC000000  000000DC 00 00000000
000000E0 1F 0000100C  000000E4 00 00000000  000000E4 00 00000000
// Final data memory words
000000FC 0000100C  00000100 FFFFFFFD
00000104 00000000  00000108 FC000000

//--- filelist.f
core_pkg.sv
core_regfile.sv
core_ifu.sv
core_idu.sv
core_alu.sv
core_bru.sv
core_lsu.sv
core_wbu.sv
core_top.sv
core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module core_tb -f filelist.f -o core_sim
./obj_dir/core_sim > sim.log
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
